//--- src/tlc_pkg.sv
`default_nettype none

package tlc_pkg;

	////////////////////////////////////////
	// Chain geometry
	////////////////////////////////////////
	localparam int NUM_LANES = 4;     // TLC5940 chains driven side by side
	localparam int GS_BITS   = 192;   // 16 channels x 12 bit per chain
	localparam int CUP_BITS  = 36;    // 3 channels x 12 bit for one cup
	localparam int NUM_CUPS  = 5;
	localparam int LANE_BITS = CUP_BITS * NUM_CUPS;   // 180 bits per lane

	////////////////////////////////////////
	// Timing in system clocks
	////////////////////////////////////////
	// Small values so a simulation stays short
	localparam int SCLK_HALF   = 4;   // sclk half period
	localparam int GSCLK_HALF  = 2;   // gsclk half period
	localparam int XLAT_CYCLES = 3;   // xlat high time
	localparam int TICK_W      = 4;   // Width of the short divider counters

	// Plain vector types
	typedef logic [GS_BITS-1:0]   gs_word_t;     // One chain's grayscale word
	typedef logic [LANE_BITS-1:0] cup_data_t;    // Five cup slices of one lane
	typedef logic [2:0]           cup_idx_t;     // Active cup, binary
	typedef logic [NUM_LANES-1:0] lane_bits_t;   // One bit per chain
	typedef logic [7:0]           bit_cnt_t;     // Bit position in a word
	typedef logic [TICK_W-1:0]    tick_cnt_t;    // Half period and xlat counts

	// Host frame, lane0 in the top bits
	typedef struct packed {
		cup_data_t lane0;
		cup_data_t lane1;
		cup_data_t lane2;
		cup_data_t lane3;
	} frame_t;

	// One latch worth of data for all chains
	typedef struct packed {
		gs_word_t word0;
		gs_word_t word1;
		gs_word_t word2;
		gs_word_t word3;
	} shift_job_t;

	////////////////////////////////////////
	// Sequencer states
	////////////////////////////////////////
	typedef enum logic [2:0] {
		SEQ_BUILD,     // Assemble job for the current cup
		SEQ_SHIFT,     // req held until shifter acks
		SEQ_BLANK,     // blank high ahead of xlat
		SEQ_XLAT,      // xlat pulse
		SEQ_RELEASE    // Drop blank and step the cup
	} seq_state_t;

endpackage

`default_nettype wire

//--- src/tlc_frame_capture.sv
`timescale 1ns/1ps
`default_nettype none

// Host side of the frame handshake
// Four-phase req/ack, one store per request
module tlc_frame_capture (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire tlc_pkg::frame_t  frame_in,    // Held stable by host while req is high
	input  wire                   frame_req,
	output logic                  frame_ack,
	output tlc_pkg::frame_t       frame        // Last stored frame
);

	logic store;   // First cycle of a new request

	// req high with ack still low marks a fresh request
	assign store = frame_req && !frame_ack;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////
	// ack follows req one cycle late
	// Rises the cycle after the store and falls the cycle after req drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame_ack <= 1'b0;
		end else begin
			frame_ack <= frame_req;
		end
	end

	////////////////////////////////////////
	// Frame register
	////////////////////////////////////////
	// All zero until the host sends something
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			frame <= '0;
		end else if (store) begin
			frame <= frame_in;   // Replaces any older frame
		end
	end

endmodule

`default_nettype wire

//--- src/tlc_cup_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

// Walks the cups 0..4 and runs one shift and latch per cup
module tlc_cup_sequencer (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire tlc_pkg::frame_t  frame,
	input  wire                   shift_ack,
	output logic                  shift_req,
	output tlc_pkg::shift_job_t   job,
	output logic                  xlat,
	output logic                  blank
);

	tlc_pkg::seq_state_t state;
	tlc_pkg::cup_idx_t   cup_idx;    // Cup being built and latched
	tlc_pkg::tick_cnt_t  xlat_cnt;   // Cycles xlat has been high

	// Slice idx of a lane at bits 36*idx upward, rest zero
	function automatic tlc_pkg::gs_word_t place_slice(
		input tlc_pkg::cup_data_t data,
		input tlc_pkg::cup_idx_t  idx
	);
		tlc_pkg::gs_word_t word;
		word = '0;
		word[idx*tlc_pkg::CUP_BITS +: tlc_pkg::CUP_BITS] =
			data[idx*tlc_pkg::CUP_BITS +: tlc_pkg::CUP_BITS];
		return word;
	endfunction

	////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= tlc_pkg::SEQ_BUILD;
			cup_idx   <= '0;
			xlat_cnt  <= '0;
			shift_req <= 1'b0;
			xlat      <= 1'b0;
			blank     <= 1'b1;   // LEDs dark until first latch
		end else begin
			unique case (state)
				tlc_pkg::SEQ_BUILD: begin
					shift_req <= 1'b1;   // job is written on this same edge
					state     <= tlc_pkg::SEQ_SHIFT;
				end
				tlc_pkg::SEQ_SHIFT: begin
					if (shift_ack) begin
						shift_req <= 1'b0;
						blank     <= 1'b1;   // One cycle ahead of xlat
						state     <= tlc_pkg::SEQ_BLANK;
					end
				end
				tlc_pkg::SEQ_BLANK: begin
					xlat     <= 1'b1;
					xlat_cnt <= '0;
					state    <= tlc_pkg::SEQ_XLAT;
				end
				tlc_pkg::SEQ_XLAT: begin
					if (xlat_cnt == tlc_pkg::tick_cnt_t'(tlc_pkg::XLAT_CYCLES - 1)) begin
						xlat  <= 1'b0;
						state <= tlc_pkg::SEQ_RELEASE;
					end else begin
						xlat_cnt <= xlat_cnt + 1'b1;
					end
				end
				tlc_pkg::SEQ_RELEASE: begin
					blank <= 1'b0;   // gsclk starts over from here
					if (cup_idx == tlc_pkg::cup_idx_t'(tlc_pkg::NUM_CUPS - 1))
						cup_idx <= '0;
					else
						cup_idx <= cup_idx + 1'b1;
					state <= tlc_pkg::SEQ_BUILD;
				end
				default: state <= tlc_pkg::SEQ_BUILD;
			endcase
		end
	end

	// Job payload, sampled from the frame once per cup
	always_ff @(posedge clk) begin
		if (state == tlc_pkg::SEQ_BUILD) begin
			job.word0 <= place_slice(frame.lane0, cup_idx);
			job.word1 <= place_slice(frame.lane1, cup_idx);
			job.word2 <= place_slice(frame.lane2, cup_idx);
			job.word3 <= place_slice(frame.lane3, cup_idx);
		end
	end

endmodule

`default_nettype wire

//--- src/tlc_serial_shifter.sv
`timescale 1ns/1ps
`default_nettype none

// Serializes four grayscale words MSB first with its own sclk
module tlc_serial_shifter (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire tlc_pkg::shift_job_t   job,
	input  wire                        shift_req,
	output logic                       shift_ack,
	output tlc_pkg::lane_bits_t        sin,
	output logic                       sclk
);

	tlc_pkg::gs_word_t  job_words [tlc_pkg::NUM_LANES];   // job split per lane
	tlc_pkg::gs_word_t  sr [tlc_pkg::NUM_LANES];          // Shift registers
	tlc_pkg::bit_cnt_t  bit_cnt;                          // Bits already clocked out
	tlc_pkg::tick_cnt_t half_cnt;                         // sclk half period count
	logic req_q;       // req delayed for edge detect
	logic busy;
	logic load;        // Rising edge of req
	logic half_done;   // sclk toggles this cycle
	logic fall;        // sclk falls this cycle
	logic last_bit;

	assign job_words[0] = job.word0;
	assign job_words[1] = job.word1;
	assign job_words[2] = job.word2;
	assign job_words[3] = job.word3;

	assign load      = shift_req && !req_q && !busy;
	assign half_done = busy && (half_cnt == tlc_pkg::tick_cnt_t'(tlc_pkg::SCLK_HALF - 1));
	assign fall      = half_done && sclk;
	assign last_bit  = (bit_cnt == tlc_pkg::bit_cnt_t'(tlc_pkg::GS_BITS - 1));

	////////////////////////////////////////
	// Bit timing and handshake
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req_q     <= 1'b0;
			busy      <= 1'b0;
			bit_cnt   <= '0;
			half_cnt  <= '0;
			sclk      <= 1'b0;
			sin       <= '0;
			shift_ack <= 1'b0;
		end else begin
			req_q <= shift_req;
			if (load) begin
				busy     <= 1'b1;
				bit_cnt  <= '0;
				half_cnt <= '0;
				sclk     <= 1'b0;   // Low half comes first
				for (int l = 0; l < tlc_pkg::NUM_LANES; l++)
					sin[l] <= job_words[l][tlc_pkg::GS_BITS-1];   // Bit 191 up front
			end else if (busy) begin
				if (half_done) begin
					half_cnt <= '0;
					sclk     <= ~sclk;
					if (fall) begin
						if (last_bit) begin
							busy      <= 1'b0;   // sclk parks low
							shift_ack <= 1'b1;
						end else begin
							bit_cnt <= bit_cnt + 1'b1;
							for (int l = 0; l < tlc_pkg::NUM_LANES; l++)
								sin[l] <= sr[l][tlc_pkg::GS_BITS-2];   // Next MSB
						end
					end
				end else begin
					half_cnt <= half_cnt + 1'b1;
				end
			end
			if (!shift_req)
				shift_ack <= 1'b0;   // Return to zero once req has gone
		end
	end

	// Data path, shifted in step with sin
	always_ff @(posedge clk) begin
		for (int l = 0; l < tlc_pkg::NUM_LANES; l++) begin
			if (load)
				sr[l] <= job_words[l];
			else if (fall && !last_bit)
				sr[l] <= sr[l] << 1;
		end
	end

endmodule

`default_nettype wire

//--- src/tlc_gsclk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Grayscale clock for the TLC5940 PWM counters
module tlc_gsclk_gen (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  blank,   // High clears the chip's GS count
	output logic gsclk
);

	tlc_pkg::tick_cnt_t cnt;
	logic gs_q;   // Divider output before masking

	// Plain 50% divider, restarted by blank
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= '0;
			gs_q <= 1'b0;
		end else if (blank) begin
			cnt  <= '0;
			gs_q <= 1'b0;   // Next window starts from a low phase
		end else if (cnt == tlc_pkg::tick_cnt_t'(tlc_pkg::GSCLK_HALF - 1)) begin
			cnt  <= '0;
			gs_q <= ~gs_q;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// blank is a flop output so no glitch here
	assign gsclk = gs_q && !blank;

endmodule

`default_nettype wire

//--- src/tlc_driver_top.sv
`timescale 1ns/1ps
`default_nettype none

// Four TLC5940 chains, five cups lit in turn
module tlc_driver_top (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire tlc_pkg::frame_t  frame_in,
	input  wire                   frame_req,
	output logic                  frame_ack,
	output tlc_pkg::lane_bits_t   sin,     // One serial line per chain
	output logic                  sclk,
	output logic                  xlat,
	output logic                  blank,
	output logic                  gsclk
);

	tlc_pkg::frame_t     frame;       // Stored host frame
	tlc_pkg::shift_job_t job;         // Words for the current cup
	logic                shift_req;
	logic                shift_ack;

	tlc_frame_capture i_capture (
		.clk       (clk),
		.rst_n     (rst_n),
		.frame_in  (frame_in),
		.frame_req (frame_req),
		.frame_ack (frame_ack),
		.frame     (frame)
	);

	tlc_cup_sequencer i_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.frame     (frame),
		.shift_ack (shift_ack),
		.shift_req (shift_req),
		.job       (job),
		.xlat      (xlat),
		.blank     (blank)
	);

	tlc_serial_shifter i_shifter (
		.clk       (clk),
		.rst_n     (rst_n),
		.job       (job),
		.shift_req (shift_req),
		.shift_ack (shift_ack),
		.sin       (sin),
		.sclk      (sclk)
	);

	// Free running apart from blank
	tlc_gsclk_gen i_gsclk (
		.clk   (clk),
		.rst_n (rst_n),
		.blank (blank),
		.gsclk (gsclk)
	);

endmodule

`default_nettype wire

//--- test/tlc_driver_asserts.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol rules on the driver outputs
module tlc_driver_asserts (
	input wire clk,
	input wire rst_n,
	input wire frame_req,
	input wire frame_ack,
	input wire sclk,
	input wire xlat,
	input wire blank,
	input wire gsclk
);

	////////////////////////////////////////
	// Latch window
	////////////////////////////////////////
	xlat_in_blank: assert property (@(posedge clk) disable iff (!rst_n) xlat |-> blank)
		else $error("xlat high while blank is low");

	// No shifting during the latch
	sclk_quiet: assert property (@(posedge clk) disable iff (!rst_n) xlat |-> !sclk)
		else $error("sclk high while xlat is high");

	gsclk_parked: assert property (@(posedge clk) disable iff (!rst_n) blank |-> !gsclk)
		else $error("gsclk high while blank is high");   // GS counter restarts clean

	////////////////////////////////////////
	// Host handshake
	////////////////////////////////////////
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(frame_ack) |-> $past(frame_req))
		else $error("frame_ack rose without frame_req");

endmodule

bind tlc_driver_top tlc_driver_asserts i_asserts (
	.clk       (clk),
	.rst_n     (rst_n),
	.frame_req (frame_req),
	.frame_ack (frame_ack),
	.sclk      (sclk),
	.xlat      (xlat),
	.blank     (blank),
	.gsclk     (gsclk)
);

`default_nettype wire

//--- test/tlc_driver_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tlc_driver_tb;

	localparam int CLK_NS       = 8;
	localparam int LATCH_CYCLES = tlc_pkg::GS_BITS * 2 * tlc_pkg::SCLK_HALF + 20;
	localparam int WATCHDOG_NS  = 16 * LATCH_CYCLES * CLK_NS;   // 16 latches worth
	localparam int HS_LIMIT     = 8;                            // Handshake give-up in cycles

	logic                clk = 1'b0;
	logic                rst_n;
	tlc_pkg::frame_t     frame_in;
	logic                frame_req;
	logic                frame_ack;
	tlc_pkg::lane_bits_t sin;
	logic                sclk;
	logic                xlat;
	logic                blank;
	logic                gsclk;

	int errors     = 0;
	int latch_cnt  = 0;   // xlat rises seen
	int cup_cnt    = 0;   // Own cup count 0..4
	int sclk_rises = 0;   // Since last latch
	int xlat_hi    = 0;
	int gs_run     = 0;   // Cycles gsclk has held its level
	int pend_from  = 0;   // First latch sure to carry pend_frame
	logic [31:0]         rng_state;
	tlc_pkg::gs_word_t   collected [tlc_pkg::NUM_LANES];   // sin bits MSB first
	tlc_pkg::frame_t     ref_frame  = '0;   // Frame in effect and zero until a load
	tlc_pkg::frame_t     pend_frame = '0;
	logic                pend_valid = 1'b0;
	logic                blank_due  = 1'b0;   // blank must be low on the next sample
	logic                sclk_q;
	logic                xlat_q;
	logic                blank_q;
	logic                gsclk_q;

	tlc_driver_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.frame_in  (frame_in),
		.frame_req (frame_req),
		.frame_ack (frame_ack),
		.sin       (sin),
		.sclk      (sclk),
		.xlat      (xlat),
		.blank     (blank),
		.gsclk     (gsclk)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Reference placement of slice cup at bits 36*cup upward with zeros elsewhere
	function automatic tlc_pkg::gs_word_t expected_word(input tlc_pkg::frame_t f,
			input int lane, input int cup);
		tlc_pkg::cup_data_t data;
		tlc_pkg::gs_word_t  word;
		case (lane)
			0:       data = f.lane0;
			1:       data = f.lane1;
			2:       data = f.lane2;
			default: data = f.lane3;
		endcase
		word = '0;
		for (int i = 0; i < tlc_pkg::CUP_BITS; i++)
			word[cup * tlc_pkg::CUP_BITS + i] = data[cup * tlc_pkg::CUP_BITS + i];
		return word;
	endfunction

	task automatic random_frame(output tlc_pkg::frame_t f);
		logic [23*32-1:0] bits;
		bits = '0;
		for (int i = 0; i < 23; i++) begin
			rng_state = xorshift32(rng_state);
			bits[i*32 +: 32] = rng_state;
		end
		f = bits[$bits(tlc_pkg::frame_t)-1:0];   // Top 16 bits dropped
	endtask

	task automatic report_mismatch(input string name, input tlc_pkg::gs_word_t got,
			input tlc_pkg::gs_word_t exp);
		errors++;
		$display("error %s: got %0h expected %0h at %0t", name, got, exp, $time);
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("%s at %0t", what, $time);
	endtask

	task automatic next_edge();
		@(posedge clk);
		#1;   // Inputs move just after the edge
	endtask

	task automatic wait_latches(input int target);
		while (latch_cnt < target)
			@(posedge clk);
	endtask

	// Host side of a four-phase frame load
	task automatic send_frame(input tlc_pkg::frame_t f);
		int waited;
		next_edge();
		frame_in  = f;
		frame_req = 1'b1;
		waited    = 0;
		while (!frame_ack && waited < HS_LIMIT) begin
			next_edge();
			waited++;
		end
		if (!frame_ack) begin
			report_failure("frame_ack never rose after frame_req");
		end else begin
			if (waited > 2)
				report_mismatch("frame_ack latency", tlc_pkg::gs_word_t'(waited), 'd2);
			pend_frame = f;
			pend_from  = latch_cnt + 2;   // Next latch may still be old data
			pend_valid = 1'b1;
		end
		frame_req = 1'b0;
		waited    = 0;
		while (frame_ack && waited < HS_LIMIT) begin
			next_edge();
			waited++;
		end
		if (frame_ack)
			report_failure("frame_ack stayed high after frame_req fell");
	endtask

	// One latch worth of sin against the reference
	task automatic compare_latch();
		logic              ok_ref;
		logic              ok_pend;
		tlc_pkg::gs_word_t exp;
		latch_cnt++;
		if (pend_valid && latch_cnt >= pend_from) begin
			ref_frame  = pend_frame;
			pend_valid = 1'b0;
		end
		ok_ref  = 1'b1;
		ok_pend = pend_valid && (latch_cnt == pend_from - 1);   // Either frame is fine here
		for (int l = 0; l < tlc_pkg::NUM_LANES; l++) begin
			if (collected[l] !== expected_word(ref_frame, l, cup_cnt))
				ok_ref = 1'b0;
			if (collected[l] !== expected_word(pend_frame, l, cup_cnt))
				ok_pend = 1'b0;
		end
		if (!ok_ref && !ok_pend) begin
			for (int l = 0; l < tlc_pkg::NUM_LANES; l++) begin
				exp = expected_word(ref_frame, l, cup_cnt);
				if (collected[l] !== exp)
					report_mismatch($sformatf("sin[%0d] latch %0d cup %0d", l, latch_cnt,
						cup_cnt), collected[l], exp);
			end
		end
		if (sclk_rises != tlc_pkg::GS_BITS)
			report_mismatch("sclk rises per latch", tlc_pkg::gs_word_t'(sclk_rises),
				tlc_pkg::gs_word_t'(tlc_pkg::GS_BITS));
		if (!blank_q)
			report_failure("xlat rose without blank high the cycle before");
		sclk_rises = 0;
		cup_cnt    = (cup_cnt == tlc_pkg::NUM_CUPS - 1) ? 0 : cup_cnt + 1;
	endtask

	////////////////////////////////////////
	// Compare process sampling mid-cycle
	////////////////////////////////////////
	always @(negedge clk) begin
		if (!rst_n) begin
			sclk_q  = 1'b0;
			xlat_q  = 1'b0;
			blank_q = 1'b1;
			gsclk_q = 1'b0;
		end else begin
			if (sclk && !sclk_q) begin   // sin is mid-bit here
				for (int l = 0; l < tlc_pkg::NUM_LANES; l++)
					collected[l] = {collected[l][tlc_pkg::GS_BITS-2:0], sin[l]};
				sclk_rises++;
			end
			if (xlat && !xlat_q)
				compare_latch();
			if (xlat) begin
				xlat_hi++;
				if (sclk)
					report_failure("sclk high while xlat is high");
			end
			if (blank_due) begin
				blank_due = 1'b0;
				if (blank)
					report_failure("blank still high one cycle after xlat fell");
			end
			if (!xlat && xlat_q) begin
				if (xlat_hi != tlc_pkg::XLAT_CYCLES)
					report_mismatch("xlat high cycles", tlc_pkg::gs_word_t'(xlat_hi),
						tlc_pkg::gs_word_t'(tlc_pkg::XLAT_CYCLES));
				xlat_hi   = 0;
				blank_due = 1'b1;   // Falls on the following cycle
			end
			if (!blank && blank_q && (xlat_q || latch_cnt == 0))
				report_failure("blank fell before the latch was done");
			if (blank) begin   // Window closed so gsclk stays parked
				gs_run = 0;
				if (gsclk)
					report_failure("gsclk high while blank is high");
			end else if (gs_run == 0 || gsclk == gsclk_q) begin
				gs_run++;
				if (gs_run == tlc_pkg::GSCLK_HALF + 1)
					report_failure("gsclk stopped toggling while blank is low");
			end else begin
				if (gs_run != tlc_pkg::GSCLK_HALF)
					report_mismatch("gsclk half period", tlc_pkg::gs_word_t'(gs_run),
						tlc_pkg::gs_word_t'(tlc_pkg::GSCLK_HALF));
				gs_run = 1;
			end
			sclk_q  = sclk;
			xlat_q  = xlat;
			blank_q = blank;
			gsclk_q = gsclk;
		end
	end

	initial begin
		tlc_pkg::frame_t f;
		rst_n     = 1'b0;
		frame_req = 1'b0;
		frame_in  = '0;
		rng_state = 32'h3a85;
		repeat (10) @(posedge clk);
		#1 rst_n = 1'b1;
		@(negedge clk);
		if (blank !== 1'b1)
			report_failure("blank not high after reset");
		if ({xlat, sclk, gsclk, sin, frame_ack} !== '0)
			report_mismatch("xlat sclk gsclk sin frame_ack", tlc_pkg::gs_word_t'({xlat,
				sclk, gsclk, sin, frame_ack}), '0);
		wait_latches(5);    // Still the all-zero frame
		random_frame(f);
		send_frame(f);
		wait_latches(11);   // Cups 0..4 and back to 0
		random_frame(f);
		send_frame(f);      // Replaces the first one mid-run
		wait_latches(15);
		repeat (4) @(posedge clk);
		$display("latches %0d, errors %0d", latch_cnt, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("run did not finish in time, %0d latches seen", latch_cnt);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- tlc_driver.f
src/tlc_pkg.sv
src/tlc_frame_capture.sv
src/tlc_cup_sequencer.sv
src/tlc_serial_shifter.sv
src/tlc_gsclk_gen.sv
src/tlc_driver_top.sv
test/tlc_driver_asserts.sv
test/tlc_driver_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the TLC5940 driver testbench with Verilator

set -u
cd "$(dirname "$0")"

BUILD_DIR=build
LOG=sim.log
EXE=tlc_driver_sim

mkdir -p "$BUILD_DIR"
if [ $? -ne 0 ]; then
	echo "cannot create $BUILD_DIR"
	exit 1
fi

verilator --binary --timing --assert -j 0 \
	--top-module tlc_driver_tb \
	-Mdir "$BUILD_DIR" -o "$EXE" \
	-f tlc_driver.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation passed"
exit 0
